/* hw/rv_pkg.sv */
package rv_pkg;

	// Datapath widths
	typedef logic [31:0] word_t;
	typedef logic [11:0] pc_t;        // Byte address into imem
	typedef logic [4:0]  reg_idx_t;
	typedef logic [9:0]  mem_idx_t;   // Word index, either memory
	typedef logic [3:0]  byte_en_t;
	typedef logic [2:0]  alu_op_t;
	typedef logic [13:0] bus_addr_t;
	typedef logic [15:0] cycles_t;

	// ALU operations
	localparam alu_op_t ALU_ADD    = 3'd0;
	localparam alu_op_t ALU_SUB    = 3'd1;
	localparam alu_op_t ALU_AND    = 3'd2;
	localparam alu_op_t ALU_OR     = 3'd3;
	localparam alu_op_t ALU_XOR    = 3'd4;
	localparam alu_op_t ALU_PASS_B = 3'd5;  // LUI

	// Major opcodes of the supported subset
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	// Host address map, region in bits 13:12
	localparam logic [1:0]  REGION_IMEM = 2'd0;
	localparam logic [1:0]  REGION_DMEM = 2'd1;
	localparam logic [1:0]  REGION_CTRL = 2'd2;
	localparam logic [11:0] CTRL_OFS    = 12'h000;  // Budget write starts a run
	localparam logic [11:0] STATUS_OFS  = 12'h004;  // {done, busy}

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* hw/tcm.sv */
`timescale 1ns/1ps

module tcm #(
	parameter int MEM_WORDS = 1024
) (
	input  logic             clk,
	// Core side
	input  rv_pkg::byte_en_t core_we,
	input  rv_pkg::mem_idx_t core_idx,
	input  rv_pkg::word_t    core_wdata,
	output rv_pkg::word_t    core_rdata,
	// Host side
	input  rv_pkg::byte_en_t host_we,
	input  rv_pkg::mem_idx_t host_idx,
	input  rv_pkg::word_t    host_wdata,
	output rv_pkg::word_t    host_rdata
);
	import rv_pkg::*;

	word_t mem [MEM_WORDS];

	// Per-byte writes
	// Host assignment comes last so it wins on a shared word
	always_ff @(posedge clk) begin
		for (int b = 0; b < 4; b++) begin
			if (core_we[b])
				mem[core_idx][8*b +: 8] <= core_wdata[8*b +: 8];
			if (host_we[b])
				mem[host_idx][8*b +: 8] <= host_wdata[8*b +: 8];
		end
	end

	// Async reads on both ports
	assign core_rdata = mem[core_idx];
	assign host_rdata = mem[host_idx];

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wr_en,
	input  rv_pkg::reg_idx_t wr_idx,
	input  rv_pkg::word_t    wr_data,
	input  rv_pkg::reg_idx_t rs1_idx,
	input  rv_pkg::reg_idx_t rs2_idx,
	output rv_pkg::word_t    rs1_data,
	output rv_pkg::word_t    rs2_data
);
	import rv_pkg::*;

	word_t regs [32];
	logic  wr_live;  // Write that actually lands

	assign wr_live = wr_en && (wr_idx != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_live) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Write-through covers the WB to ID distance
	assign rs1_data = (wr_live && wr_idx == rs1_idx) ? wr_data : regs[rs1_idx];
	assign rs2_data = (wr_live && wr_idx == rs2_idx) ? wr_data : regs[rs2_idx];

	// x0 stays zero across every write and bypass
	a_x0_rs1: assert property (@(posedge clk) disable iff (!rst_n)
		(rs1_idx == '0) |-> (rs1_data == '0));
	a_x0_rs2: assert property (@(posedge clk) disable iff (!rst_n)
		(rs2_idx == '0) |-> (rs2_data == '0));

endmodule

/* hw/core.sv */
`timescale 1ns/1ps

module core (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             run,       // Pipeline advances
	input  logic             restart,   // Fetch from 0, drop in-flight work
	input  rv_pkg::word_t    inst,
	input  rv_pkg::word_t    dm_rdata,
	output rv_pkg::pc_t      pc,
	output rv_pkg::mem_idx_t dm_idx,
	output rv_pkg::byte_en_t dm_we,
	output rv_pkg::word_t    dm_wdata
);
	import rv_pkg::*;

	localparam logic [1:0] WB_ALU  = 2'd0;
	localparam logic [1:0] WB_LOAD = 2'd1;
	localparam logic [1:0] WB_IMM  = 2'd2;

	logic  commit;  // Side effects allowed this cycle
	pc_t   pc_q;
	// IF/ID
	logic  id_v;
	word_t id_inst;
	// ID/EX
	logic     ex_v, ex_wr, ex_store, ex_use_imm;
	logic [1:0] ex_sel;
	alu_op_t  ex_op;
	reg_idx_t ex_rd, ex_rs1, ex_rs2;
	word_t    ex_rs1_data, ex_rs2_data, ex_imm;
	// EX/MEM
	logic     mem_v, mem_wr, mem_store;
	logic [1:0] mem_sel;
	reg_idx_t mem_rd;
	word_t    mem_alu, mem_sdata, mem_imm;
	// MEM/WB
	logic     wb_v, wb_wr;
	logic [1:0] wb_sel;
	reg_idx_t wb_rd;
	word_t    wb_alu, wb_load, wb_imm, wb_data;

	// Stale stages from an earlier run never commit on the restart cycle
	assign commit = run && !restart;

	//////////////////////////////////////////////////
	// Fetch
	assign pc = restart ? '0 : pc_q;  // First fetch of a run is word 0

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q  <= '0;
			id_v  <= 1'b0;
			ex_v  <= 1'b0;
			mem_v <= 1'b0;
			wb_v  <= 1'b0;
		end else if (run) begin
			pc_q  <= pc + 12'd4;          // No branches, straight line
			id_v  <= 1'b1;
			ex_v  <= id_v && !restart;
			mem_v <= ex_v && !restart;
			wb_v  <= mem_v && !restart;
		end else if (restart) begin
			pc_q  <= '0;
			id_v  <= 1'b0;
			ex_v  <= 1'b0;
			mem_v <= 1'b0;
			wb_v  <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Decode
	reg_idx_t   id_rs1, id_rs2;
	word_t      id_rs1_data, id_rs2_data, id_imm;
	logic       id_wr, id_store, id_use_imm;
	logic [1:0] id_sel;
	alu_op_t    id_op;

	assign id_rs1 = id_inst[19:15];
	assign id_rs2 = id_inst[24:20];

	always_comb begin
		id_wr      = 1'b0;  // Anything unmatched falls out as NOP
		id_store   = 1'b0;
		id_use_imm = 1'b0;
		id_op      = ALU_ADD;
		id_sel     = WB_ALU;
		id_imm     = {{20{id_inst[31]}}, id_inst[31:20]};  // I-type
		case (id_inst[6:0])
			OPC_OP: begin
				id_wr = 1'b1;
				case (id_inst[14:12])
					3'b000:  id_op = id_inst[30] ? ALU_SUB : ALU_ADD;
					3'b100:  id_op = ALU_XOR;
					3'b110:  id_op = ALU_OR;
					3'b111:  id_op = ALU_AND;
					default: id_wr = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				id_wr      = (id_inst[14:12] == 3'b000);  // ADDI only
				id_use_imm = 1'b1;
			end
			OPC_LUI: begin
				id_wr      = 1'b1;
				id_use_imm = 1'b1;
				id_op      = ALU_PASS_B;  // Keeps MEM forward a plain ALU tap
				id_sel     = WB_IMM;
				id_imm     = {id_inst[31:12], 12'b0};
			end
			OPC_LOAD: begin
				id_wr      = (id_inst[14:12] == 3'b010);  // LW
				id_use_imm = 1'b1;
				id_sel     = WB_LOAD;
			end
			OPC_STORE: begin
				id_store   = (id_inst[14:12] == 3'b010);  // SW
				id_use_imm = 1'b1;
				id_imm     = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
			end
			default: ;
		endcase
	end

	regfile rf_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (wb_v && wb_wr && commit),
		.wr_idx   (wb_rd),
		.wr_data  (wb_data),
		.rs1_idx  (id_rs1),
		.rs2_idx  (id_rs2),
		.rs1_data (id_rs1_data),
		.rs2_data (id_rs2_data)
	);

	//////////////////////////////////////////////////
	// Execute
	word_t ex_a, ex_b, ex_opb, ex_alu;
	logic  fwd_mem_a, fwd_mem_b, fwd_wb_a, fwd_wb_b;

	// A LW in MEM has no data yet, software keeps one slot free
	assign fwd_mem_a = mem_v && mem_wr && (mem_rd != '0) && (mem_rd == ex_rs1);
	assign fwd_mem_b = mem_v && mem_wr && (mem_rd != '0) && (mem_rd == ex_rs2);
	assign fwd_wb_a  = wb_v && wb_wr && (wb_rd != '0) && (wb_rd == ex_rs1);
	assign fwd_wb_b  = wb_v && wb_wr && (wb_rd != '0) && (wb_rd == ex_rs2);

	// Younger MEM result beats WB
	assign ex_a   = fwd_mem_a ? mem_alu : (fwd_wb_a ? wb_data : ex_rs1_data);
	assign ex_b   = fwd_mem_b ? mem_alu : (fwd_wb_b ? wb_data : ex_rs2_data);
	assign ex_opb = ex_use_imm ? ex_imm : ex_b;

	always_comb begin
		case (ex_op)
			ALU_ADD:    ex_alu = ex_a + ex_opb;
			ALU_SUB:    ex_alu = ex_a - ex_opb;
			ALU_AND:    ex_alu = ex_a & ex_opb;
			ALU_OR:     ex_alu = ex_a | ex_opb;
			ALU_XOR:    ex_alu = ex_a ^ ex_opb;
			ALU_PASS_B: ex_alu = ex_opb;
			default:    ex_alu = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Memory and writeback
	assign dm_idx   = mem_alu[11:2];  // Word access only
	assign dm_wdata = mem_sdata;
	assign dm_we    = {4{mem_v && mem_store && commit}};

	always_comb begin
		case (wb_sel)
			WB_LOAD: wb_data = wb_load;
			WB_IMM:  wb_data = wb_imm;
			default: wb_data = wb_alu;
		endcase
	end

	// Stage payloads, qualified by the valid bits above
	always_ff @(posedge clk) begin
		if (run) begin
			id_inst     <= inst;
			ex_wr       <= id_wr;
			ex_store    <= id_store;
			ex_use_imm  <= id_use_imm;
			ex_sel      <= id_sel;
			ex_op       <= id_op;
			ex_rd       <= id_inst[11:7];
			ex_rs1      <= id_rs1;
			ex_rs2      <= id_rs2;
			ex_rs1_data <= id_rs1_data;
			ex_rs2_data <= id_rs2_data;
			ex_imm      <= id_imm;
			mem_wr      <= ex_wr;
			mem_store   <= ex_store;
			mem_sel     <= ex_sel;
			mem_rd      <= ex_rd;
			mem_alu     <= ex_alu;
			mem_sdata   <= ex_b;      // Forwarded store data
			mem_imm     <= ex_imm;
			wb_wr       <= mem_wr;
			wb_sel      <= mem_sel;
			wb_rd       <= mem_rd;
			wb_alu      <= mem_alu;
			wb_load     <= dm_rdata;
			wb_imm      <= mem_imm;
		end
	end

	// Stores only while the timer enables the core
	a_store_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		(dm_we != '0) |-> run);

endmodule

/* hw/run_timer.sv */
`timescale 1ns/1ps

module run_timer (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,    // One-cycle pulse from host
	input  rv_pkg::cycles_t budget,
	output logic            run,
	output logic            restart,
	output logic            busy,
	output logic            done
);
	import rv_pkg::*;

	cycles_t count;  // Cycles left in this run

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count   <= '0;
			restart <= 1'b0;
			done    <= 1'b0;
		end else begin
			restart <= start;  // Lines up with first busy cycle
			if (start) begin
				count <= budget;
				done  <= (budget == '0);  // Empty budget finishes at once
			end else if (count != '0) begin
				count <= count - cycles_t'(1);
				done  <= (count == cycles_t'(1));
			end
		end
	end

	assign busy = (count != '0);
	assign run  = busy;

	// done only after the count has drained
	a_busy_done: assert property (@(posedge clk) disable iff (!rst_n)
		!(busy && done));

endmodule

/* hw/axil_ctrl.sv */
`timescale 1ns/1ps

module axil_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	// Write address and data
	input  logic              awvalid,
	output logic              awready,
	input  rv_pkg::bus_addr_t awaddr,
	input  logic              wvalid,
	output logic              wready,
	input  rv_pkg::word_t     wdata,
	input  rv_pkg::byte_en_t  wstrb,
	// Write response
	output logic              bvalid,
	input  logic              bready,
	output logic [1:0]        bresp,
	// Read address and data
	input  logic              arvalid,
	output logic              arready,
	input  rv_pkg::bus_addr_t araddr,
	output logic              rvalid,
	input  logic              rready,
	output rv_pkg::word_t     rdata,
	output logic [1:0]        rresp,
	// Memory host ports
	output rv_pkg::byte_en_t  im_we,
	output rv_pkg::byte_en_t  dm_we,
	output rv_pkg::mem_idx_t  host_idx,
	output rv_pkg::word_t     host_wdata,
	input  rv_pkg::word_t     im_rdata,
	input  rv_pkg::word_t     dm_rdata,
	// Run timer
	output logic              start,
	output rv_pkg::cycles_t   budget,
	input  logic              busy,
	input  logic              done
);
	import rv_pkg::*;

	typedef enum logic [1:0] {IDLE, WRESP, RRESP} state_t;

	state_t     state;
	logic       wr_acc, rd_acc;         // Handshake this cycle
	logic [1:0] wr_region, rd_region;
	logic       wr_ctrl, wr_err;
	word_t      rd_word;

	// Writes first, both channels together
	assign wr_acc  = (state == IDLE) && awvalid && wvalid;
	assign rd_acc  = (state == IDLE) && !(awvalid && wvalid) && arvalid;
	assign awready = wr_acc;
	assign wready  = wr_acc;
	assign arready = rd_acc;
	assign bvalid  = (state == WRESP);
	assign rvalid  = (state == RRESP);

	assign wr_region = awaddr[13:12];
	assign rd_region = araddr[13:12];
	assign wr_ctrl   = (wr_region == REGION_CTRL) && (awaddr[11:0] == CTRL_OFS);
	// Memories and CTRL locked while the core runs
	assign wr_err    = busy && (wr_region == REGION_IMEM || wr_region == REGION_DMEM || wr_ctrl);

	//////////////////////////////////////////////////
	// Side effects on acceptance
	assign host_idx   = wr_acc ? awaddr[11:2] : araddr[11:2];
	assign host_wdata = wdata;
	assign im_we      = (wr_acc && !wr_err && wr_region == REGION_IMEM) ? wstrb : '0;
	assign dm_we      = (wr_acc && !wr_err && wr_region == REGION_DMEM) ? wstrb : '0;
	assign start      = wr_acc && !wr_err && wr_ctrl;
	assign budget     = wdata[15:0];

	always_comb begin
		case (rd_region)
			REGION_IMEM: rd_word = im_rdata;
			REGION_DMEM: rd_word = dm_rdata;
			REGION_CTRL: rd_word = (araddr[11:0] == STATUS_OFS) ? {30'b0, done, busy} : '0;
			default:     rd_word = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// FSM
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (wr_acc)
						state <= WRESP;
					else if (rd_acc)
						state <= RRESP;
				end
				WRESP:   if (bready) state <= IDLE;  // Held until taken
				RRESP:   if (rready) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Response payloads
	always_ff @(posedge clk) begin
		if (wr_acc)
			bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
		if (rd_acc) begin
			rdata <= rd_word;
			rresp <= RESP_OKAY;
		end
	end

	// One response channel at a time
	a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
		!(bvalid && rvalid));

endmodule

/* hw/soc_top.sv */
`timescale 1ns/1ps

module soc_top #(
	parameter int MEM_WORDS = 1024
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              awvalid,
	output logic              awready,
	input  rv_pkg::bus_addr_t awaddr,
	input  logic              wvalid,
	output logic              wready,
	input  rv_pkg::word_t     wdata,
	input  rv_pkg::byte_en_t  wstrb,
	output logic              bvalid,
	input  logic              bready,
	output logic [1:0]        bresp,
	input  logic              arvalid,
	output logic              arready,
	input  rv_pkg::bus_addr_t araddr,
	output logic              rvalid,
	input  logic              rready,
	output rv_pkg::word_t     rdata,
	output logic [1:0]        rresp
);
	import rv_pkg::*;

	// Host side
	byte_en_t im_we, dm_we_host;
	mem_idx_t host_idx;
	word_t    host_wdata, im_rdata, dm_rdata_host;
	// Timer
	logic     start, busy, done, run, restart;
	cycles_t  budget;
	// Core side
	pc_t      pc;
	word_t    inst, dm_rdata, dm_wdata;
	mem_idx_t dm_idx;
	byte_en_t dm_we;

	axil_ctrl ctrl_i (
		.clk (clk), .rst_n (rst_n),
		.awvalid (awvalid), .awready (awready), .awaddr (awaddr),
		.wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
		.bvalid (bvalid), .bready (bready), .bresp (bresp),
		.arvalid (arvalid), .arready (arready), .araddr (araddr),
		.rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
		.im_we (im_we), .dm_we (dm_we_host),
		.host_idx (host_idx), .host_wdata (host_wdata),
		.im_rdata (im_rdata), .dm_rdata (dm_rdata_host),
		.start (start), .budget (budget), .busy (busy), .done (done)
	);

	run_timer timer_i (
		.clk (clk), .rst_n (rst_n),
		.start (start), .budget (budget),
		.run (run), .restart (restart), .busy (busy), .done (done)
	);

	core core_i (
		.clk (clk), .rst_n (rst_n),
		.run (run), .restart (restart),
		.inst (inst), .dm_rdata (dm_rdata),
		.pc (pc), .dm_idx (dm_idx), .dm_we (dm_we), .dm_wdata (dm_wdata)
	);

	// Instruction memory, read-only from the core
	tcm #(.MEM_WORDS (MEM_WORDS)) imem_i (
		.clk (clk),
		.core_we ('0), .core_idx (pc[11:2]), .core_wdata ('0), .core_rdata (inst),
		.host_we (im_we), .host_idx (host_idx), .host_wdata (host_wdata),
		.host_rdata (im_rdata)
	);

	tcm #(.MEM_WORDS (MEM_WORDS)) dmem_i (
		.clk (clk),
		.core_we (dm_we), .core_idx (dm_idx), .core_wdata (dm_wdata),
		.core_rdata (dm_rdata),
		.host_we (dm_we_host), .host_idx (host_idx), .host_wdata (host_wdata),
		.host_rdata (dm_rdata_host)
	);

endmodule

/* dv/soc_tb.sv */
`timescale 1ns/1ps

module soc_tb;
	import rv_pkg::*;

	localparam int HANDSHAKE_LIMIT = 64;   // Cycles per channel wait
	localparam int POLL_LIMIT      = 100;  // STATUS reads per run

	logic       clk;
	logic       rst_n;
	logic       awvalid, awready, wvalid, wready;
	bus_addr_t  awaddr;
	word_t      wdata;
	byte_en_t   wstrb;
	logic       bvalid, bready;
	logic [1:0] bresp;
	logic       arvalid, arready, rvalid, rready;
	bus_addr_t  araddr;
	word_t      rdata;
	logic [1:0] rresp;

	soc_top #(.MEM_WORDS (1024)) soc_top_i (
		.clk (clk), .rst_n (rst_n),
		.awvalid (awvalid), .awready (awready), .awaddr (awaddr),
		.wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
		.bvalid (bvalid), .bready (bready), .bresp (bresp),
		.arvalid (arvalid), .arready (arready), .araddr (araddr),
		.rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
	);

	always #5 clk = ~clk;  // 10 ns period

	//////////////////////////////////////////////////
	// Checks
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0d ns: %s gave %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR %0d ns: %s resp %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic apply_reset();
		repeat (3) @(posedge clk);  // Low across three edges
		rst_n <= 1'b1;
	endtask

	//////////////////////////////////////////////////
	// AXI4-Lite master
	task automatic axil_write(input bus_addr_t addr, input word_t data, input byte_en_t strb,
			output logic [1:0] resp);
		int waited;
		int hold;
		repeat ($urandom_range(0, 2)) @(posedge clk);  // Idle gap
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr  <= addr;
		wvalid  <= 1'b1;
		wdata   <= data;
		wstrb   <= strb;
		waited = 0;
		@(negedge clk);
		while (!(awready && wready)) begin
			waited++;
			if (waited > HANDSHAKE_LIMIT)
				abort_run("Timeout: the slave never raised awready and wready");
			@(negedge clk);
		end
		@(posedge clk);  // Address and data transfer here
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		hold = $urandom_range(0, 3);
		repeat (hold) @(posedge clk);  // Back-pressure on B
		bready <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!bvalid) begin
			waited++;
			if (waited > HANDSHAKE_LIMIT)
				abort_run("Timeout: no write response arrived");
			@(negedge clk);
		end
		resp = bresp;
		@(posedge clk);  // B taken
		bready <= 1'b0;
	endtask

	task automatic axil_read(input bus_addr_t addr, output word_t data, output logic [1:0] resp);
		int waited;
		int hold;
		repeat ($urandom_range(0, 2)) @(posedge clk);
		@(posedge clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		waited = 0;
		@(negedge clk);
		while (!arready) begin
			waited++;
			if (waited > HANDSHAKE_LIMIT)
				abort_run("Timeout: the slave never raised arready");
			@(negedge clk);
		end
		@(posedge clk);
		arvalid <= 1'b0;
		hold = $urandom_range(0, 3);
		repeat (hold) @(posedge clk);  // Back-pressure on R
		rready <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!rvalid) begin
			waited++;
			if (waited > HANDSHAKE_LIMIT)
				abort_run("Timeout: no read data arrived");
			@(negedge clk);
		end
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// Poll STATUS until done, then busy must be low
	task automatic wait_done();
		word_t      status;
		logic [1:0] resp;
		int         polls;
		polls  = 0;
		status = '0;
		while (!status[1]) begin
			if (polls == POLL_LIMIT)
				abort_run("Timeout: the core run never reported done");
			polls++;
			axil_read({REGION_CTRL, STATUS_OFS}, status, resp);
			check_resp("STATUS read", resp, RESP_OKAY);
		end
		check_word("STATUS after run", status, 32'h0000_0002);
	endtask

	//////////////////////////////////////////////////
	// Vector player
	initial begin : main
		int               fd;
		int               got_n;
		int               cmds;
		logic [7:0]       cmd;
		logic [31:0]      f_addr, f_data, f_strb, f_resp;
		word_t            rd_data;
		logic [1:0]       resp;
		logic [8*160-1:0] skipped;

		void'($urandom(32'h3360_740f));
		clk     = 1'b0;
		rst_n   = 1'b0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		apply_reset();

		fd = $fopen("dv/soc_vectors.txt", "r");
		if (fd == 0)
			abort_run("Cannot open the vector file dv/soc_vectors.txt");
		cmds  = 0;
		got_n = $fscanf(fd, " %c", cmd);
		while (got_n == 1) begin
			case (cmd)
				"#": got_n = $fgets(skipped, fd);  // Comment line
				"W", "P": begin
					got_n = $fscanf(fd, " %h %h %h", f_addr, f_data, f_strb);
					if (got_n != 3)
						abort_run("Malformed write line in the vector file");
					if (cmd == "W") begin
						got_n = $fscanf(fd, " %h", f_resp);
						if (got_n != 1)
							abort_run("Write line without an expected response");
					end else begin
						f_resp = 32'(RESP_SLVERR);  // Refused while busy
					end
					axil_write(f_addr[13:0], f_data, f_strb[3:0], resp);
					check_resp($sformatf("write %h", f_addr[13:0]), resp, f_resp[1:0]);
					cmds++;
				end
				"R": begin
					got_n = $fscanf(fd, " %h %h %h", f_addr, f_data, f_resp);
					if (got_n != 3)
						abort_run("Malformed read line in the vector file");
					axil_read(f_addr[13:0], rd_data, resp);
					check_resp($sformatf("read %h", f_addr[13:0]), resp, f_resp[1:0]);
					check_word($sformatf("read %h", f_addr[13:0]), rd_data, f_data);
					cmds++;
				end
				"G": begin
					got_n = $fscanf(fd, " %h", f_data);
					if (got_n != 1)
						abort_run("Go line without a cycle budget");
					axil_write({REGION_CTRL, CTRL_OFS}, {16'b0, f_data[15:0]}, 4'hf, resp);
					check_resp("CTRL start", resp, RESP_OKAY);
					wait_done();
					cmds++;
				end
				"D": begin
					wait_done();  // Run started by an earlier W
					cmds++;
				end
				default: abort_run($sformatf("Unknown command %c in the vector file", cmd));
			endcase
			got_n = $fscanf(fd, " %c", cmd);
		end
		$fclose(fd);
		if (cmds == 0) begin
			abort_run("The vector file holds no commands");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

/* tb.f */
hw/rv_pkg.sv
hw/tcm.sv
hw/regfile.sv
hw/core.sv
hw/run_timer.sv
hw/axil_ctrl.sv
hw/soc_top.sv
dv/soc_tb.sv

/* Makefile */
SIM     := verilator
FLAGS   := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP     := soc_tb
FLIST   := tb.f
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* dv/soc_vectors.txt */
# Columns: W addr data strb resp | P addr data strb | R addr data resp | G budget | D
# All fields hex, addr is the 14-bit bus address, resp 0 is OKAY and 2 is SLVERR
# Partial strobes merge into the prior word
W 1040 11223344 f 0
W 1040 aabbccdd 5 0
R 1040 11bb33dd 0
W 1044 ffffffff f 0
W 1044 00000000 a 0
R 1044 00ff00ff 0
# Program: ADDI LUI ADD SUB XOR OR AND, SW SW, LW ADDI ADD, SW SW SW SW
W 0000 5a500093 f 0
W 0004 f0f0f137 f 0
W 0008 001101b3 f 0
W 000c 40308233 f 0
W 0010 003242b3 f 0
W 0014 0042e333 f 0
W 0018 0022f3b3 f 0
W 001c 10702823 f 0
W 0020 10602623 f 0
W 0024 12002403 f 0
W 0028 7ff00493 f 0
W 002c 00940533 f 0
W 0030 10a02a23 f 0
W 0034 10502423 f 0
W 0038 10402223 f 0
W 003c 10302023 f 0
R 0024 12002403 0
# Load source, then a marker in every store target
W 1120 12345678 f 0
W 1100 5e5e0100 f 0
W 1104 5e5e0104 f 0
W 1108 5e5e0108 f 0
W 110c 5e5e010c f 0
W 1110 5e5e0110 f 0
W 1114 5e5e0114 f 0
# Short run of 14 cycles, only the stores at words 7 and 8 land
G 000e
R 1110 f0f0e000 0
R 110c fffff5a5 0
R 1114 5e5e0114 0
R 1108 5e5e0108 0
R 1104 5e5e0104 0
R 1100 5e5e0100 0
# Full run of 20 cycles
G 0014
R 1100 f0f0f5a5 0
R 1104 0f0f1000 0
R 1108 ffffe5a5 0
R 110c fffff5a5 0
R 1110 f0f0e000 0
R 1114 12345e77 0
# Long run, host writes refused until done
W 2000 00000080 f 0
P 1040 00000000 f
P 0000 00000000 f
P 2000 00000005 f
R 2004 00000001 0
D
R 2004 00000002 0
R 1040 11bb33dd 0
R 0000 5a500093 0
R 1114 12345e77 0
